// ==== common/melody_pkg.sv ====
package melody_pkg;

    // ##############################
    // Widths
    // ##############################

    localparam int NOTE_ADDR_W   = 6;       // Up to 64 notes per song
    localparam int HALF_PERIOD_W = 20;      // Holds the slowest half-period at 50 MHz

    // ##############################
    // Note word
    // ##############################

    // Codes 12 to 14 are unused and play as a rest
    typedef enum logic [3:0] {
        SEMI_C    = 4'd0,
        SEMI_CS   = 4'd1,
        SEMI_D    = 4'd2,
        SEMI_DS   = 4'd3,
        SEMI_E    = 4'd4,
        SEMI_F    = 4'd5,
        SEMI_FS   = 4'd6,
        SEMI_G    = 4'd7,
        SEMI_GS   = 4'd8,
        SEMI_A    = 4'd9,
        SEMI_AS   = 4'd10,
        SEMI_B    = 4'd11,
        SEMI_REST = 4'd15
    } semitone_t;

    typedef struct packed {
        logic [1:0] octave;                 // Each step halves the period
        semitone_t  semi;
    } pitch_t;

    typedef struct packed {
        pitch_t     pitch;
        logic [2:0] dur;                    // Length is dur + 1 beats
    } note_t;

    localparam pitch_t REST_PITCH = '{octave: 2'd0, semi: SEMI_REST};
    localparam note_t  REST_NOTE  = '{pitch: REST_PITCH, dur: 3'd0};

    // ##############################
    // Semitone half-periods
    // ##############################

    // Octave 0 starts at middle C, counts are 25e6 / f
    localparam logic [HALF_PERIOD_W-1:0] SEMITONE_HALF_PERIOD [12] = '{
        20'd95555,                          // C4
        20'd90194,
        20'd85132,                          // D4
        20'd80353,
        20'd75843,                          // E4
        20'd71586,                          // F4
        20'd67569,
        20'd63776,                          // G4
        20'd60197,
        20'd56818,                          // A4, 440 Hz
        20'd53630,
        20'd50620                           // B4
    };

endpackage

// ==== design/note_rom.sv ====
`timescale 1ns/100ps

module note_rom
    import melody_pkg::*;
#(
    parameter int SONG_LEN = 36
) (
    input  logic                   sys_clk,
    input  logic [NOTE_ADDR_W-1:0] addr,
    output note_t                  note
);

    note_t song_mem [SONG_LEN];

    initial begin
        $readmemh("design/song.mem", song_mem);
    end

    // Registered read, one cycle of latency
    always_ff @(posedge sys_clk) begin
        if (addr < NOTE_ADDR_W'(SONG_LEN)) begin
            note <= song_mem[addr];
        end else begin
            note <= REST_NOTE;              // Past the song end
        end
    end

endmodule

// ==== design/note_sequencer.sv ====
`timescale 1ns/100ps

module note_sequencer
    import melody_pkg::*;
#(
    parameter int TICKS_PER_BEAT = 12_500_000,
    parameter int SONG_LEN       = 36
) (
    input  logic                   sys_clk,
    input  logic                   sys_rst_n,
    input  logic                   play_en,
    input  note_t                  rom_note,
    output logic [NOTE_ADDR_W-1:0] note_addr,
    output pitch_t                 cur_pitch,
    output logic                   note_start
);

    localparam int CNT_W = $clog2(8 * TICKS_PER_BEAT + 1);
    localparam logic [NOTE_ADDR_W-1:0] LAST_ADDR = NOTE_ADDR_W'(SONG_LEN - 1);

    logic [CNT_W-1:0] dur_cnt;              // Cycles since the address changed
    logic [CNT_W-1:0] note_len;
    logic             rom_vld;              // rom_note matches note_addr
    logic             note_live;
    logic             step;

    // ##############################
    // Duration compare
    // ##############################

    assign note_len = CNT_W'(({1'b0, rom_note.dur} + 4'd1) * TICKS_PER_BEAT);

    // The fetch cycle counts toward the note, so the interval is exact
    assign step = play_en && rom_vld && (dur_cnt >= note_len - 1'b1);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            dur_cnt   <= '0;
            rom_vld   <= 1'b0;
            note_addr <= '0;
        end else if (play_en) begin
            if (step) begin
                dur_cnt <= '0;
                rom_vld <= 1'b0;            // New word arrives next cycle
                if (note_addr == LAST_ADDR) begin
                    note_addr <= '0;
                end else begin
                    note_addr <= note_addr + 1'b1;
                end
            end else begin
                dur_cnt <= dur_cnt + 1'b1;
                rom_vld <= 1'b1;
            end
        end
    end

    // ##############################
    // Note start
    // ##############################

    // Pitch is captured once so the tone stays put for the whole note
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            note_live  <= 1'b0;
            note_start <= 1'b0;
            cur_pitch  <= REST_PITCH;
        end else if (play_en) begin
            note_start <= rom_vld && !note_live;
            note_live  <= rom_vld && !step;
            if (rom_vld && !note_live) begin
                cur_pitch <= rom_note.pitch;
            end
        end else begin
            note_start <= 1'b0;
        end
    end

endmodule

// ==== tone_gen/pitch_table.sv ====
`timescale 1ns/100ps

module pitch_table
    import melody_pkg::*;
#(
    parameter int TONE_SHIFT = 0
) (
    input  pitch_t                   pitch,
    input  logic [1:0]               shift,
    output logic [HALF_PERIOD_W-1:0] half_period,
    output logic                     is_rest
);

    logic [3:0]               semi_idx;
    logic [HALF_PERIOD_W-1:0] base_period;
    logic [HALF_PERIOD_W-1:0] shifted;

    // Octave arrives on its own port, the caller picks the transpose
    always_comb begin
        is_rest = (pitch.semi > SEMI_B);    // Unused codes play as rest
        if (is_rest) begin
            semi_idx = 4'd0;
        end else begin
            semi_idx = pitch.semi;
        end

        base_period = SEMITONE_HALF_PERIOD[semi_idx];
        shifted     = base_period >> (int'(shift) + TONE_SHIFT);

        // A zero count would stall the divider
        if (shifted == '0) begin
            half_period = HALF_PERIOD_W'(1);
        end else begin
            half_period = shifted;
        end
    end

endmodule

// ==== tone_gen/tone_gen.sv ====
`timescale 1ns/100ps

module tone_gen
    import melody_pkg::*;
#(
    parameter int TONE_SHIFT = 0
) (
    input  logic   sys_clk,
    input  logic   sys_rst_n,
    input  logic   play_en,
    input  pitch_t pitch,
    input  logic   note_start,
    output logic   buzzer
);

    logic [HALF_PERIOD_W-1:0] half_period;
    logic [HALF_PERIOD_W-1:0] div_cnt;
    logic                     is_rest;
    logic                     start_pend;   // note_start seen while paused
    logic                     restart;

    pitch_table #(
        .TONE_SHIFT (TONE_SHIFT)
    ) u_pitch_table (
        .pitch       (pitch),
        .shift       (pitch.octave),
        .half_period (half_period),
        .is_rest     (is_rest)
    );

    assign restart = note_start || start_pend || is_rest;

    // ##############################
    // Half-period divider
    // ##############################

    // Nothing moves while paused, so the pin never changes then
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            div_cnt    <= '0;
            buzzer     <= 1'b0;
            start_pend <= 1'b0;
        end else if (play_en) begin
            start_pend <= 1'b0;
            if (restart) begin
                div_cnt <= half_period - 1'b1;
                buzzer  <= 1'b0;            // Every note starts on a low phase
            end else if (div_cnt == '0) begin
                div_cnt <= half_period - 1'b1;
                buzzer  <= ~buzzer;
            end else begin
                div_cnt <= div_cnt - 1'b1;
            end
        end else if (note_start) begin
            start_pend <= 1'b1;
        end
    end

endmodule

// ==== design/melody_player.sv ====
`timescale 1ns/100ps

module melody_player
    import melody_pkg::*;
#(
    parameter int TICKS_PER_BEAT = 12_500_000,  // 0.25 s per beat at 50 MHz
    parameter int SONG_LEN       = 36,
    parameter int TONE_SHIFT     = 0
) (
    input  logic                   sys_clk,
    input  logic                   sys_rst_n,
    input  logic                   play_en,
    output logic                   buzzer,
    output logic [NOTE_ADDR_W-1:0] note_addr
);

    note_t  rom_note;
    pitch_t cur_pitch;
    logic   note_start;

    note_rom #(
        .SONG_LEN (SONG_LEN)
    ) u_note_rom (
        .sys_clk (sys_clk),
        .addr    (note_addr),
        .note    (rom_note)
    );

    note_sequencer #(
        .TICKS_PER_BEAT (TICKS_PER_BEAT),
        .SONG_LEN       (SONG_LEN)
    ) u_note_sequencer (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .play_en    (play_en),
        .rom_note   (rom_note),
        .note_addr  (note_addr),
        .cur_pitch  (cur_pitch),
        .note_start (note_start)
    );

    tone_gen #(
        .TONE_SHIFT (TONE_SHIFT)
    ) u_tone_gen (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .play_en    (play_en),
        .pitch      (cur_pitch),
        .note_start (note_start),
        .buzzer     (buzzer)
    );

endmodule

// ==== tb/melody_player_tb.sv ====
`timescale 1ns/100ps

module melody_player_tb
    import melody_pkg::*;
();

    localparam int TICKS_PER_BEAT  = 40;
    localparam int SONG_LEN        = 36;
    localparam int TONE_SHIFT      = 12;
    localparam int CLK_PERIOD      = 8;
    localparam int STEADY_LOOPS    = 2;     // Passes with play_en held high
    localparam int TOTAL_LOOPS     = 3;
    localparam int START_DELAY     = 3;     // note_start on the 2nd cycle, reload on the 3rd
    localparam int LOOP_MAX_CYCLES = SONG_LEN * 8 * TICKS_PER_BEAT;
    localparam int WATCHDOG_CYCLES = TOTAL_LOOPS * LOOP_MAX_CYCLES + LOOP_MAX_CYCLES / 2 + 100;

    logic                   sys_clk;
    logic                   sys_rst_n;
    logic                   play_en;
    logic                   buzzer;
    logic [NOTE_ADDR_W-1:0] note_addr;

    note_t                  song [SONG_LEN];

    // Reference model state
    logic [NOTE_ADDR_W-1:0] exp_addr;
    logic                   exp_buzzer;
    pitch_t                 snd_pitch;      // Pitch the buzzer is playing
    int                     hi_cnt;         // Play cycles in the current note
    int                     start_cnt;
    int                     phase_cnt;

    // Measured on the DUT side
    logic [NOTE_ADDR_W-1:0] last_addr;
    logic                   last_buzzer;
    int                     meas_cyc;
    int                     meas_lows;
    int                     wraps;
    int                     burst_left;

    melody_player #(
        .TICKS_PER_BEAT (TICKS_PER_BEAT),
        .SONG_LEN       (SONG_LEN),
        .TONE_SHIFT     (TONE_SHIFT)
    ) DUT (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .play_en   (play_en),
        .buzzer    (buzzer),
        .note_addr (note_addr)
    );

    always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

    // ##############################
    // Rules of the player
    // ##############################

    function automatic int note_cycles(note_t n);
        return (int'(n.dur) + 1) * TICKS_PER_BEAT;
    endfunction

    function automatic logic pitch_is_rest(pitch_t p);
        return (p.semi > SEMI_B);           // Codes 12 to 14 rest as well
    endfunction

    function automatic int half_cycles(pitch_t p);
        int h;
        h = int'(SEMITONE_HALF_PERIOD[p.semi]) >> (int'(p.octave) + TONE_SHIFT);
        if (h < 1) begin
            h = 1;
        end
        return h;
    endfunction

    // ##############################
    // Compare tasks
    // ##############################

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_addr(string name, logic [NOTE_ADDR_W-1:0] got,
                              logic [NOTE_ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            abort_run();
        end
    endtask

    task automatic check_interval(string name, int got, int exp);
        if (got != exp) begin
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            abort_run();
        end
    endtask

    task automatic check_buzzer(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            abort_run();
        end
    endtask

    // ##############################
    // Model and stimulus
    // ##############################

    task automatic tone_tick();
        if (pitch_is_rest(snd_pitch)) begin
            exp_buzzer = 1'b0;
        end else begin
            phase_cnt++;
            if (phase_cnt == half_cycles(snd_pitch)) begin
                exp_buzzer = ~exp_buzzer;
                phase_cnt  = 0;
            end
        end
    endtask

    // One clock edge, pe is the play_en level seen at that edge
    task automatic advance_model(logic pe);
        if (pe) begin
            if (start_cnt == START_DELAY - 1) begin
                snd_pitch  = song[exp_addr].pitch;  // New note starts on a low phase
                phase_cnt  = 0;
                exp_buzzer = 1'b0;
                start_cnt++;
            end else begin
                if (start_cnt < START_DELAY) begin
                    start_cnt++;
                end
                tone_tick();
            end
            hi_cnt++;
            if (hi_cnt == note_cycles(song[exp_addr])) begin
                if (exp_addr == NOTE_ADDR_W'(SONG_LEN - 1)) begin
                    exp_addr = '0;
                end else begin
                    exp_addr = exp_addr + NOTE_ADDR_W'(1);
                end
                hi_cnt    = 0;
                start_cnt = 0;
            end
        end
    endtask

    task automatic check_outputs(logic pe);
        meas_cyc++;
        if (!pe) begin
            meas_lows++;
            check_buzzer("buzzer while paused", buzzer, last_buzzer);
        end
        if (note_addr != last_addr) begin
            check_interval("note interval", meas_cyc,
                           note_cycles(song[last_addr]) + meas_lows);
            if (note_addr == '0) begin
                wraps++;
            end
            meas_cyc  = 0;
            meas_lows = 0;
        end
        check_addr("note_addr", note_addr, exp_addr);
        check_buzzer("buzzer", buzzer, exp_buzzer);
        last_addr   = note_addr;
        last_buzzer = buzzer;
    endtask

    // Short pause bursts, about one cycle in ten
    task automatic drive_play_en();
        if (wraps < STEADY_LOOPS) begin
            play_en = 1'b1;
        end else if (burst_left > 0) begin
            play_en = 1'b0;
            burst_left--;
        end else if ($urandom_range(0, 31) == 0) begin
            play_en    = 1'b0;
            burst_left = int'($urandom_range(1, 4));
        end else begin
            play_en = 1'b1;
        end
    endtask

    // ##############################
    // Main sequence
    // ##############################

    initial begin
        void'($urandom(55));
        sys_clk    = 1'b0;
        sys_rst_n  = 1'b1;
        play_en    = 1'b1;
        $readmemh("design/song.mem", song);

        exp_addr    = '0;
        exp_buzzer  = 1'b0;
        snd_pitch   = REST_PITCH;
        hi_cnt      = 0;
        start_cnt   = 0;
        phase_cnt   = 0;
        last_addr   = '0;
        last_buzzer = 1'b0;
        meas_cyc    = 0;
        meas_lows   = 0;
        wraps       = 0;
        burst_left  = 0;

        #1;
        sys_rst_n = 1'b0;                   // Clean falling edge for the async reset
        repeat (2) @(posedge sys_clk);
        #1;
        sys_rst_n = 1'b1;
        check_addr("note_addr after reset", note_addr, '0);
        check_buzzer("buzzer after reset", buzzer, 1'b0);

        while (wraps < TOTAL_LOOPS) begin
            @(posedge sys_clk);
            #1;
            advance_model(play_en);
            check_outputs(play_en);
            drive_play_en();
        end

        $display("Played %0d passes of %0d notes", wraps, SONG_LEN);
        $display("All tests passed");
        $finish;
    end

    // Three passes at the longest note, with room for the pauses
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, playback did not finish", WATCHDOG_CYCLES);
        abort_run();
    end

endmodule

// ==== design/song.mem ====
// Each line holds one 9-bit note word
// Bits 8 to 7 are the octave, 6 to 3 the semitone and 2 to 0 the duration code
0A1
0A1
0A9
0B9
0B9
0A9
0A1
091
081
081
091
0A1
0A2
090
093
079
049
059
082
038
101
121
13B
078
181
1D8
152
0B1
019
00C
0EA
0C5
0A6
07A
087
07F

// ==== melody_player.f ====
common/melody_pkg.sv
design/note_rom.sv
design/note_sequencer.sv
tone_gen/pitch_table.sv
tone_gen/tone_gen.sv
design/melody_player.sv
tb/melody_player_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the melody player testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module melody_player_tb \
    -f melody_player.f -o melody_player_sim \
    && ./obj_dir/melody_player_sim > sim.log 2>&1 \
    || echo "Build or simulation returned an error"

[ -f sim.log ] && cat sim.log

grep -q "All tests passed" sim.log && { echo "Simulation PASSED"; exit 0; } \
    || { echo "Simulation FAILED"; exit 1; }
